// ==== flist.f ====
+incdir+common
common/blur_geom_pkg.sv
common/blur_ctrl_pkg.sv
blur_core/blur_lane.sv
blur_core/window_buffer.sv
blur_core/strip_sequencer.sv
blur_core/result_sender.sv
verilog/gaussian_blur_top.sv
tests/tb_gaussian_blur.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_gaussian_blur
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) && echo "Simulation passed" || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_gaussian_blur.sv ====
`include "blur_defs.svh"

module tb_gaussian_blur;
  import blur_geom_pkg::*;

  localparam int ROWS      = `BLUR_IMG_ROWS;
  localparam int COLS      = `BLUR_IMG_COLS;
  localparam int LANES     = `BLUR_LANES;
  localparam int PW        = `BLUR_PIX_W;
  localparam int GROUPS    = ROWS * `BLUR_STRIPS;
  localparam int PIX_BITS  = $bits(strip_pix_t);
  localparam int ROW_BITS  = $bits(row_idx_t);
  localparam int STRIP_LSB = PIX_BITS + ROW_BITS;
  localparam int GRP_W     = STRIP_LSB + $bits(strip_idx_t);
  // Roughly five frames of 36 steps with stalls, ample margin
  localparam int MAX_CYCLES = 4000;

  // Consumer credit return policies
  localparam int RET_NOW  = 0;
  localparam int RET_HOLD = 1;
  localparam int RET_SLOW = 2;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       start;
  logic       img_rd;
  row_idx_t   img_addr;
  row_data_t  img_dout = '0;
  logic       out_valid;
  row_idx_t   out_row;
  strip_idx_t out_strip;
  strip_pix_t out_pixels;
  logic       credit_return = 1'b0;
  logic       done;

  pix_t             img [ROWS][COLS];
  integer           seed;
  int               cyc = 0;
  int               ret_mode = RET_NOW;
  int               owed = 0;
  // Strip, row and pixels of each received group
  logic [GRP_W-1:0] got_q [$];
  int               rd_cyc_q [$];

  gaussian_blur_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .img_rd        (img_rd),
    .img_addr      (img_addr),
    .img_dout      (img_dout),
    .out_valid     (out_valid),
    .out_row       (out_row),
    .out_strip     (out_strip),
    .out_pixels    (out_pixels),
    .credit_return (credit_return),
    .done          (done)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the frame never completed", cyc);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  // Image memory, data one cycle after the read
  always @(posedge clk) begin
    if (img_rd) begin
      img_dout <= row_word(img_addr);
      if (img_addr != '0) begin
        rd_cyc_q.push_back(cyc);
      end
    end
  end

  // Output consumer
  always @(posedge clk) begin
    int lat;
    credit_return <= 1'b0;
    if (out_valid) begin
      got_q.push_back({out_strip, out_row, out_pixels});
      owed = owed + 1;
      // Rows 0 to 6 follow the read of the row below
      if (out_row != row_idx_t'(ROWS - 1)) begin
        assert (rd_cyc_q.size() > 0) else report_error("group without a matching image read");
        lat = cyc - rd_cyc_q.pop_front();
        assert (lat == 3) else
          report_error($sformatf("strip %0d row %0d came %0d cycles after its read, expected 3",
                                 out_strip, out_row, lat));
      end
    end
    if ((owed > 0) && ((ret_mode == RET_NOW) || ((ret_mode == RET_SLOW) && (cyc % 8 == 0)))) begin
      credit_return <= 1'b1;
      owed = owed - 1;
    end
  end

  task automatic report_error(string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  function automatic row_data_t row_word(row_idx_t r);
    row_data_t w;
    for (int c = 0; c < COLS; c++) begin
      w[c*PW +: PW] = img[r][c];
    end
    return w;
  endfunction

  // Zero outside the image
  function automatic int pix_at(int r, int c);
    if (r < 0 || r >= ROWS || c < 0 || c >= COLS) begin
      return 0;
    end
    return int'(img[r][c]);
  endfunction

  // 1-2-1 by 1-2-1 kernel, sum divided by 16
  function automatic pix_t blur_ref(int r, int c);
    int acc;
    acc = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        acc += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * pix_at(r + dr, c + dc);
      end
    end
    return pix_t'(acc / 16);
  endfunction

  task automatic fill_random();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img[r][c] = pix_t'($random(seed));
      end
    end
  endtask

  task automatic fill_const(pix_t v);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img[r][c] = v;
      end
    end
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done();
    do begin
      @(negedge clk);
    end while (!done);
  endtask

  task automatic run_frame();
    got_q.delete();
    pulse_start();
    wait_done();
  endtask

  task automatic check_frame();
    logic [GRP_W-1:0] g;
    int s;
    int r;
    pix_t want;
    assert (got_q.size() == GROUPS) else
      report_error($sformatf("%0d groups received, expected %0d", got_q.size(), GROUPS));
    for (int k = 0; k < GROUPS; k++) begin
      g = got_q[k];
      s = k / ROWS;
      r = k % ROWS;
      assert ((g[STRIP_LSB +: 2] == strip_idx_t'(s)) && (g[PIX_BITS +: ROW_BITS] == row_idx_t'(r)))
        else report_error($sformatf("group %0d tagged strip %0d row %0d, expected %0d %0d",
                                    k, g[STRIP_LSB +: 2], g[PIX_BITS +: ROW_BITS], s, r));
      for (int l = 0; l < LANES; l++) begin
        want = blur_ref(r, s * LANES + l);
        assert (g[l*PW +: PW] == want) else
          report_error($sformatf("row %0d col %0d is %0d, expected %0d",
                                 r, s * LANES + l, g[l*PW +: PW], want));
      end
    end
  endtask

  task automatic check_reset_state();
    repeat (3) begin
      @(negedge clk);
      assert (!out_valid && !img_rd && !done) else report_error("outputs not low after reset");
    end
  endtask

  task automatic blur_random_image();
    fill_random();
    run_frame();
    check_frame();
  endtask

  // Flat white image shows the padding levels directly
  task automatic blur_flat_image();
    int r;
    int c;
    int borders;
    pix_t want;
    fill_const(8'd255);
    run_frame();
    check_frame();
    for (int k = 0; k < GROUPS; k++) begin
      r = k % ROWS;
      for (int l = 0; l < LANES; l++) begin
        c = (k / ROWS) * LANES + l;
        borders = int'(r == 0 || r == ROWS - 1) + int'(c == 0 || c == COLS - 1);
        want = (borders == 2) ? 8'd143 : (borders == 1) ? 8'd191 : 8'd255;
        assert (got_q[k][l*PW +: PW] == want) else
          report_error($sformatf("flat row %0d col %0d is %0d, expected %0d",
                                 r, c, got_q[k][l*PW +: PW], want));
      end
    end
  endtask

  task automatic throttle_credits();
    ret_mode = RET_HOLD;
    fill_random();
    got_q.delete();
    pulse_start();
    repeat (30) @(negedge clk);
    assert (got_q.size() == `BLUR_CREDITS) else
      report_error($sformatf("%0d groups without credit return, expected 4", got_q.size()));
    repeat (30) @(negedge clk);
    assert ((got_q.size() == `BLUR_CREDITS) && !done) else
      report_error($sformatf("%0d groups sent while out of credit", got_q.size()));
    // One credit back every 8 cycles
    ret_mode = RET_SLOW;
    wait_done();
    check_frame();
    ret_mode = RET_NOW;
  endtask

  task automatic restart_frame();
    assert (done) else report_error("done dropped before the next start");
    fill_random();
    got_q.delete();
    pulse_start();
    @(negedge clk);
    assert (!done) else report_error("done still high after start");
    wait_done();
    check_frame();
  endtask

  initial begin
    seed = 17442;
    rst_n = 1'b0;
    start = 1'b0;
    fill_const(8'd0);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    blur_random_image();
    blur_flat_image();
    throttle_credits();
    restart_frame();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== verilog/gaussian_blur_top.sv ====
`include "blur_defs.svh"

module gaussian_blur_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  output logic                      img_rd,
  output blur_geom_pkg::row_idx_t   img_addr,
  input  blur_geom_pkg::row_data_t  img_dout,
  output logic                      out_valid,
  output blur_geom_pkg::row_idx_t   out_row,
  output blur_geom_pkg::strip_idx_t out_strip,
  output blur_geom_pkg::strip_pix_t out_pixels,
  input  logic                      credit_return,
  output logic                      done
);
  import blur_geom_pkg::*;
  import blur_ctrl_pkg::*;

  logic       has_credit;
  logic       reserve;
  logic       load_valid;
  logic       load_zero;
  logic       load_emit;
  tag_t       load_tag;
  logic       win_valid;
  tag_t       win_tag;
  win_row_t   win_top;
  win_row_t   win_mid;
  win_row_t   win_bot;
  strip_pix_t lane_pix;

  strip_sequencer u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .has_credit (has_credit),
    .img_rd     (img_rd),
    .img_addr   (img_addr),
    .reserve    (reserve),
    .load_valid (load_valid),
    .load_zero  (load_zero),
    .load_emit  (load_emit),
    .load_tag   (load_tag)
  );

  window_buffer u_win (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_valid (load_valid),
    .load_zero  (load_zero),
    .load_emit  (load_emit),
    .load_tag   (load_tag),
    .img_dout   (img_dout),
    .win_valid  (win_valid),
    .win_tag    (win_tag),
    .win_top    (win_top),
    .win_mid    (win_mid),
    .win_bot    (win_bot)
  );

  // One lane per strip pixel
  for (genvar g = 0; g < `BLUR_LANES; g++) begin : g_lane
    blur_lane #(
      .LANE (g)
    ) u_lane (
      .win_top  (win_top),
      .win_mid  (win_mid),
      .win_bot  (win_bot),
      .lane_pix (lane_pix[g*`BLUR_PIX_W +: `BLUR_PIX_W])
    );
  end

  result_sender u_send (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .win_valid     (win_valid),
    .win_tag       (win_tag),
    .lane_pix      (lane_pix),
    .reserve       (reserve),
    .credit_return (credit_return),
    .has_credit    (has_credit),
    .out_valid     (out_valid),
    .out_row       (out_row),
    .out_strip     (out_strip),
    .out_pixels    (out_pixels),
    .done          (done)
  );

endmodule

// ==== blur_core/result_sender.sv ====
`include "blur_defs.svh"

module result_sender (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      win_valid,
  input  blur_ctrl_pkg::tag_t       win_tag,
  input  blur_geom_pkg::strip_pix_t lane_pix,
  input  logic                      reserve,
  input  logic                      credit_return,
  output logic                      has_credit,
  output logic                      out_valid,
  output blur_geom_pkg::row_idx_t   out_row,
  output blur_geom_pkg::strip_idx_t out_strip,
  output blur_geom_pkg::strip_pix_t out_pixels,
  output logic                      done
);
  import blur_geom_pkg::*;
  import blur_ctrl_pkg::*;

  localparam int         CNT_W      = $clog2(`BLUR_CREDITS + 1);
  localparam row_idx_t   LAST_ROW   = row_idx_t'(`BLUR_IMG_ROWS - 1);
  localparam strip_idx_t LAST_STRIP = strip_idx_t'(`BLUR_STRIPS - 1);

  logic [CNT_W-1:0] credit_cnt;
  logic [CNT_W-1:0] inflight;

  // Credits not yet claimed by a group in the pipeline
  assign has_credit = credit_cnt > inflight;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      credit_cnt <= CNT_W'(`BLUR_CREDITS);
      inflight   <= '0;
      done       <= 1'b0;
    end else begin
      out_valid  <= win_valid;
      credit_cnt <= credit_cnt + CNT_W'(credit_return) - CNT_W'(out_valid);
      inflight   <= inflight + CNT_W'(reserve) - CNT_W'(out_valid);
      if (start) begin
        done <= 1'b0;
      end else if (out_valid && (out_row == LAST_ROW) && (out_strip == LAST_STRIP)) begin
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid) begin
      out_strip  <= win_tag[$bits(tag_t)-1 -: $bits(strip_idx_t)];
      out_row    <= win_tag[$bits(row_idx_t)-1:0];
      out_pixels <= lane_pix;
    end
  end

  credit_max_a: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= CNT_W'(`BLUR_CREDITS));

  // Reservation at issue must leave a credit for every send
  send_credit_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (credit_cnt != '0));

endmodule

// ==== blur_core/strip_sequencer.sv ====
`include "blur_defs.svh"

module strip_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic                    has_credit,
  output logic                    img_rd,
  output blur_geom_pkg::row_idx_t img_addr,
  output logic                    reserve,
  output logic                    load_valid,
  output logic                    load_zero,
  output logic                    load_emit,
  output blur_ctrl_pkg::tag_t     load_tag
);
  import blur_geom_pkg::*;
  import blur_ctrl_pkg::*;

  localparam row_idx_t   LAST_ROW   = row_idx_t'(`BLUR_IMG_ROWS - 1);
  localparam strip_idx_t LAST_STRIP = strip_idx_t'(`BLUR_STRIPS - 1);

  seq_state_t state;
  strip_idx_t strip;
  row_idx_t   row;
  logic       step_read;
  logic       step_zero;

  // Step 0 never emits, so it goes without credit
  always_comb begin
    step_read = (state == strip_start) || ((state == next_row) && has_credit);
    step_zero = (state == zero_fill) && has_credit;
    reserve   = ((state == next_row) || (state == zero_fill)) && has_credit;
  end

  assign img_rd   = step_read;
  assign img_addr = row;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
      strip <= '0;
      row   <= '0;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            state <= strip_start;
            strip <= '0;
            row   <= '0;
          end
        end
        strip_start: begin
          row   <= row + 1'b1;
          state <= next_row;
        end
        next_row: begin
          if (has_credit) begin
            // Wraps to 0 after the last row
            row <= row + 1'b1;
            if (row == LAST_ROW) begin
              state <= zero_fill;
            end
          end
        end
        zero_fill: begin
          if (has_credit) begin
            if (strip == LAST_STRIP) begin
              state <= idle;
            end else begin
              strip <= strip + 1'b1;
              state <= strip_start;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Load controls line up with img_dout one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_valid <= 1'b0;
      load_zero  <= 1'b0;
      load_emit  <= 1'b0;
    end else begin
      load_valid <= step_read;
      load_zero  <= step_zero;
      load_emit  <= reserve;
    end
  end

  // Emitted row is one above the loaded one
  always_ff @(posedge clk) begin
    load_tag <= {strip, row - 1'b1};
  end

  // Out of idle only row 0 is read
  img_rd_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state == idle) |=> (!img_rd || (img_addr == '0)));

endmodule

// ==== blur_core/window_buffer.sv ====
`include "blur_defs.svh"

module window_buffer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load_valid,
  input  logic                     load_zero,
  input  logic                     load_emit,
  input  blur_ctrl_pkg::tag_t      load_tag,
  input  blur_geom_pkg::row_data_t img_dout,
  output logic                     win_valid,
  output blur_ctrl_pkg::tag_t      win_tag,
  output blur_geom_pkg::win_row_t  win_top,
  output blur_geom_pkg::win_row_t  win_mid,
  output blur_geom_pkg::win_row_t  win_bot
);
  import blur_geom_pkg::*;
  import blur_ctrl_pkg::*;

  localparam int STRIP_BITS = `BLUR_LANES * `BLUR_PIX_W;

  strip_idx_t ld_strip;
  logic       ld_first;
  logic       ld_shift;
  win_row_t   cut;

  // Image row with one zero pixel on each side
  logic [(`BLUR_IMG_COLS+2)*`BLUR_PIX_W-1:0] padded;

  assign ld_strip = load_tag[$bits(tag_t)-1 -: $bits(strip_idx_t)];

  // Row 0 of a strip is the only load that emits nothing
  assign ld_first = load_valid && !load_emit;
  assign ld_shift = load_valid || load_zero;

  assign padded = {{`BLUR_PIX_W{1'b0}}, img_dout, {`BLUR_PIX_W{1'b0}}};

  // Padded index j is image column j-1, so the strip window starts at strip*lanes
  assign cut = padded[ld_strip*STRIP_BITS +: $bits(win_row_t)];

  always_ff @(posedge clk) begin
    if (ld_first) begin
      // Zero rows above the image
      win_top <= '0;
      win_mid <= '0;
      win_bot <= cut;
    end else if (ld_shift) begin
      win_top <= win_mid;
      win_mid <= win_bot;
      // Zero row below the image
      win_bot <= load_zero ? '0 : cut;
    end
  end

  always_ff @(posedge clk) begin
    if (load_emit) begin
      win_tag <= load_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid <= 1'b0;
    end else begin
      win_valid <= load_emit;
    end
  end

endmodule

// ==== blur_core/blur_lane.sv ====
`include "blur_defs.svh"

module blur_lane #(
  parameter int LANE = 0
) (
  input  blur_geom_pkg::win_row_t win_top,
  input  blur_geom_pkg::win_row_t win_mid,
  input  blur_geom_pkg::win_row_t win_bot,
  output blur_geom_pkg::pix_t     lane_pix
);
  import blur_geom_pkg::*;

  // Kernel weights sum to 16, so four extra bits
  localparam int SUM_W = `BLUR_PIX_W + 4;

  logic [SUM_W-1:0] sum;

  // 1-2-1 across the three pixels around window pixel LANE+1
  function automatic logic [SUM_W-1:0] row_sum(win_row_t r);
    pix_t p_l;
    pix_t p_c;
    pix_t p_r;
    p_l = r[LANE*`BLUR_PIX_W +: `BLUR_PIX_W];
    p_c = r[(LANE+1)*`BLUR_PIX_W +: `BLUR_PIX_W];
    p_r = r[(LANE+2)*`BLUR_PIX_W +: `BLUR_PIX_W];
    return SUM_W'(p_l) + (SUM_W'(p_c) << 1) + SUM_W'(p_r);
  endfunction

  // Vertical 1-2-1 over the row sums
  assign sum = row_sum(win_top) + (row_sum(win_mid) << 1) + row_sum(win_bot);

  // Divide by 16, truncating
  assign lane_pix = sum[SUM_W-1 -: `BLUR_PIX_W];

endmodule

// ==== common/blur_ctrl_pkg.sv ====
`include "blur_defs.svh"

package blur_ctrl_pkg;

  // Sequencer states
  typedef enum logic [1:0] {
    idle,
    strip_start,
    next_row,
    zero_fill
  } seq_state_t;

  // Strip in the high bits, output row in the low bits
  typedef logic [$clog2(`BLUR_STRIPS)+$clog2(`BLUR_IMG_ROWS)-1:0] tag_t;

endpackage

// ==== common/blur_geom_pkg.sv ====
`include "blur_defs.svh"

package blur_geom_pkg;

  // One pixel
  typedef logic [`BLUR_PIX_W-1:0] pix_t;

  // Full image row, pixel 0 in the low byte
  typedef logic [`BLUR_IMG_COLS*`BLUR_PIX_W-1:0] row_data_t;

  // Row and strip numbers
  typedef logic [$clog2(`BLUR_IMG_ROWS)-1:0] row_idx_t;
  typedef logic [$clog2(`BLUR_STRIPS)-1:0] strip_idx_t;

  // Blurred pixels of one strip, lane 0 in the low byte
  typedef logic [`BLUR_LANES*`BLUR_PIX_W-1:0] strip_pix_t;

  // Strip plus one neighbour pixel on each side
  typedef logic [(`BLUR_LANES+2)*`BLUR_PIX_W-1:0] win_row_t;

endpackage

// ==== common/blur_defs.svh ====
`ifndef BLUR_DEFS_SVH
`define BLUR_DEFS_SVH

// Pixel depth in bits
`define BLUR_PIX_W 8

// Image geometry
`define BLUR_IMG_COLS 16
`define BLUR_IMG_ROWS 8

// Pixels per strip, one blur lane each
`define BLUR_LANES 4

// Strips across the image, cols / lanes
`define BLUR_STRIPS 4

// Output slots granted by the consumer after reset
`define BLUR_CREDITS 4

`endif
